//--- rtl/vga_defs.svh
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

// 640x480 timing, pixel clock counts
`define H_TOTAL       800
`define V_TOTAL       521
`define H_PULSE       96
`define V_PULSE       2
`define H_BP          144
`define H_FP          784
`define V_BP          31
`define V_FP          511

// Bird sprite, X offsets relative to H_BP
`define FLOOR_Y       480
`define BIRD_HALF     20
`define BIRD_X0       100
`define BIRD_X1       140

// Pipe pairs
`define PIPE_W        50
`define PIPE_SPACING  345
`define GAP_TOP       75
`define GAP_BOT       215

// Grass band and score row
`define GRASS_Y       500
`define SCORE_Y0      504
`define SCORE_Y1      514
`define BAR_PITCH     10
`define BAR_W         5
`define BAR_X0        10

// Packed {red, green, blue}, 3-3-2
`define WHITE         8'b111_111_11
`define BLACK         8'b000_000_00
`define RED           8'b111_000_00
`define GREEN         8'b000_111_00
`define CYAN          8'b000_111_11

`endif

//--- rtl/flappy_pkg.sv
package flappy_pkg;

	// Raster position
	typedef logic [9:0] hcount_t;
	typedef logic [9:0] vcount_t;

	// Game inputs
	typedef logic [9:0] bird_y_t;
	typedef logic [8:0] pipe_x_t;
	typedef logic [7:0] gap_y_t;
	typedef logic [3:0] score_t;

	// VGA colour channels
	typedef logic [2:0] red_t;
	typedef logic [2:0] green_t;
	typedef logic [1:0] blue_t;

	// Seven-segment lines, active low
	typedef logic [6:0] seg_t;
	typedef logic [3:0] anode_t;

	// Digit currently lit, left to right
	typedef enum logic [1:0] {DIG_LEFT, DIG_MIDLEFT, DIG_MIDRIGHT, DIG_RIGHT} scan_state_t;

endpackage

//--- rtl/vga_timing.sv
`timescale 1ns/1ns
`include "vga_defs.svh"

module vga_timing (
	input  logic              clk,
	input  logic              clr,
	output flappy_pkg::hcount_t hc,
	output flappy_pkg::vcount_t vc,
	output logic              hsync,
	output logic              vsync,
	output logic              line_end
);

	//////////////////////////////////////////////////
	// Raster counters
	//////////////////////////////////////////////////

	// Last pixel of the line
	assign line_end = (hc == 10'(`H_TOTAL - 1));

	always_ff @(posedge clk or posedge clr)
	begin
		if (clr)
		begin
			hc <= '0;
			vc <= '0;
		end
		else if (line_end)
		begin
			hc <= '0;
			// Frame wrap on the last line
			if (vc == 10'(`V_TOTAL - 1))
				vc <= '0;
			else
				vc <= vc + 10'd1;
		end
		else
		begin
			hc <= hc + 10'd1;
		end
	end

	//////////////////////////////////////////////////
	// Sync pulses, active low
	//////////////////////////////////////////////////

	assign hsync = (hc >= 10'(`H_PULSE));
	assign vsync = (vc >= 10'(`V_PULSE));

	// Counters never leave their range
	a_hc_range: assert property (@(posedge clk) disable iff (clr) hc < 10'(`H_TOTAL));
	a_vc_range: assert property (@(posedge clk) disable iff (clr) vc < 10'(`V_TOTAL));

endmodule

//--- rtl/pixel_render.sv
`timescale 1ns/1ns
`include "vga_defs.svh"

module pixel_render (
	input  logic                clk,
	input  logic                clr,
	input  flappy_pkg::hcount_t hc,
	input  flappy_pkg::vcount_t vc,
	input  flappy_pkg::bird_y_t bird_y,
	input  flappy_pkg::pipe_x_t pipe_x,
	input  flappy_pkg::gap_y_t  gap0,
	input  flappy_pkg::gap_y_t  gap1,
	input  flappy_pkg::score_t  score,
	output flappy_pkg::red_t    red,
	output flappy_pkg::green_t  green,
	output flappy_pkg::blue_t   blue,
	output logic                collide
);

	//////////////////////////////////////////////////
	// Geometry in signed 12-bit space
	//////////////////////////////////////////////////

	// Active window
	localparam logic signed [11:0] HBP = 12'(`H_BP);
	localparam logic signed [11:0] HFP = 12'(`H_FP);
	localparam logic signed [11:0] VBP = 12'(`V_BP);
	localparam logic signed [11:0] VFP = 12'(`V_FP);

	// Bird box
	localparam logic signed [11:0] FLOOR = 12'(`FLOOR_Y);
	localparam logic signed [11:0] BHALF = 12'(`BIRD_HALF);
	localparam logic signed [11:0] BX0 = 12'(`H_BP + `BIRD_X0);
	localparam logic signed [11:0] BX1 = 12'(`H_BP + `BIRD_X1);

	// Pipes and grass
	localparam logic signed [11:0] PW = 12'(`PIPE_W);
	localparam logic signed [11:0] PSP = 12'(`PIPE_SPACING);
	localparam logic signed [11:0] GTOP = 12'(`GAP_TOP);
	localparam logic signed [11:0] GBOT = 12'(`GAP_BOT);
	localparam logic signed [11:0] GRASS = 12'(`GRASS_Y);

	// Score bar row
	localparam logic signed [11:0] SY0 = 12'(`SCORE_Y0);
	localparam logic signed [11:0] SY1 = 12'(`SCORE_Y1);
	localparam logic signed [11:0] BAR_LO = 12'(`H_BP + `BAR_X0);
	localparam logic signed [11:0] BPITCH = 12'(`BAR_PITCH);
	localparam logic signed [11:0] BW = 12'(`BAR_W);

	logic signed [11:0] hs;
	logic signed [11:0] vs;
	logic signed [11:0] bird_c;
	logic signed [11:0] p1_lo;
	logic signed [11:0] p0_lo;
	logic               active;
	logic               bar_hit;
	logic               bird_hit;
	logic               pipe0_hit;
	logic               pipe1_hit;
	logic [7:0]         rgb;

	// Solid part of one pipe pair outside its gap (gap+75 to gap+215)
	function automatic logic pipe_hit(
		input logic signed [11:0] lo,
		input logic [7:0]         gap,
		input logic signed [11:0] h,
		input logic signed [11:0] v
	);
		logic signed [11:0] g;
		g = $signed({4'b0000, gap});
		return (h > lo) && (h < lo + PW) &&
			((v < g + GTOP) || ((v > g + GBOT) && (v < GRASS)));
	endfunction

	assign hs = $signed({2'b00, hc});
	assign vs = $signed({2'b00, vc});

	// Bird centre line may go negative
	assign bird_c = FLOOR - $signed({2'b00, bird_y});

	// Pipe 0 left edge trails pipe 1 by one spacing
	assign p1_lo = HFP - $signed({3'b000, pipe_x});
	assign p0_lo = p1_lo - PSP;

	assign active = (vs >= VBP) && (vs < VFP) && (hs >= HBP) && (hs < HFP);

	assign bird_hit = (vs > bird_c - BHALF) && (vs < bird_c + BHALF) &&
		(hs > BX0) && (hs < BX1);

	assign pipe1_hit = pipe_hit(p1_lo, gap1, hs, vs);
	assign pipe0_hit = pipe_hit(p0_lo, gap0, hs, vs);

	//////////////////////////////////////////////////
	// Score bars
	//////////////////////////////////////////////////

	// Bar k lit when score >= k with one bar per pitch
	always_comb
	begin
		logic signed [11:0] lo;
		bar_hit = 1'b0;
		lo = BAR_LO;
		for (int k = 1; k < 16; k++)
		begin
			if ((score >= k) && (hs > lo) && (hs < lo + BW))
				bar_hit = 1'b1;
			lo = lo + BPITCH;
		end
		// Restrict to the score row
		bar_hit = bar_hit && (vs >= SY0) && (vs <= SY1);
	end

	//////////////////////////////////////////////////
	// Colour priority
	//////////////////////////////////////////////////

	always_comb
	begin
		if (!active)
			rgb = `BLACK;
		else if (bar_hit)
			rgb = `WHITE;
		else if (bird_hit)
			rgb = `BLACK;
		else if (pipe1_hit || pipe0_hit)
			rgb = `RED;
		else if (vs >= GRASS)
			rgb = `GREEN;
		else
			rgb = `CYAN;
	end

	assign {red, green, blue} = rgb;

	// Bird overlaps a pipe regardless of priority
	always_ff @(posedge clk or posedge clr)
	begin
		if (clr)
			collide <= 1'b0;
		else
			collide <= bird_hit && (pipe0_hit || pipe1_hit);
	end

	// Colour pins stay black for raw counter values outside the window
	a_blank: assert property (@(posedge clk)
		((hc < 10'(`H_BP)) || (hc >= 10'(`H_FP)) || (vc < 10'(`V_BP)) || (vc >= 10'(`V_FP)))
		|-> ({red, green, blue} == `BLACK));

endmodule

//--- rtl/hex_to_seg.sv
`timescale 1ns/1ns

module hex_to_seg (
	input  flappy_pkg::score_t digit,
	output flappy_pkg::seg_t   seg
);

	// Bit order g..a, low lights the segment
	always_comb
	begin
		case (digit)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0010000;
			// Letters A..F
			4'hA: seg = 7'b0001000;
			4'hB: seg = 7'b0000011;
			4'hC: seg = 7'b1000110;
			4'hD: seg = 7'b0100001;
			4'hE: seg = 7'b0000110;
			4'hF: seg = 7'b0001110;
			default: seg = 7'b1111111;
		endcase
	end

endmodule

//--- rtl/seg_scan.sv
`timescale 1ns/1ns

module seg_scan (
	input  logic               clk,
	input  logic               clr,
	input  logic               line_end,
	input  flappy_pkg::score_t score,
	output flappy_pkg::seg_t   seg,
	output flappy_pkg::anode_t an
);

	import flappy_pkg::*;

	scan_state_t state;
	scan_state_t state_nxt;
	anode_t      an_nxt;
	score_t      digit;
	seg_t        glyph;

	//////////////////////////////////////////////////
	// Next digit and its pattern
	//////////////////////////////////////////////////

	always_comb
	begin
		case (state)
			DIG_LEFT:     state_nxt = DIG_MIDLEFT;
			DIG_MIDLEFT:  state_nxt = DIG_MIDRIGHT;
			DIG_MIDRIGHT: state_nxt = DIG_RIGHT;
			default:      state_nxt = DIG_LEFT;
		endcase
	end

	// One low anode per digit
	always_comb
	begin
		case (state_nxt)
			DIG_LEFT:     an_nxt = 4'b0111;
			DIG_MIDLEFT:  an_nxt = 4'b1011;
			DIG_MIDRIGHT: an_nxt = 4'b1101;
			default:      an_nxt = 4'b1110;
		endcase
	end

	// Only the rightmost digit carries the score
	assign digit = (state_nxt == DIG_RIGHT) ? score : 4'h0;

	hex_to_seg u_glyph (
		.digit(digit),
		.seg  (glyph)
	);

	// Step once per line
	always_ff @(posedge clk or posedge clr)
	begin
		if (clr)
		begin
			state <= DIG_LEFT;
			an    <= 4'b1111;
			seg   <= 7'b1111111;
		end
		else if (line_end)
		begin
			state <= state_nxt;
			an    <= an_nxt;
			seg   <= glyph;
		end
	end

	// Never two digits lit at once
	a_one_digit: assert property (@(posedge clk) disable iff (clr) $countones(~an) <= 1);

endmodule

//--- rtl/flappy_display_top.sv
`timescale 1ns/1ns

module flappy_display_top (
	input  logic                clk,
	input  logic                clr,
	input  flappy_pkg::bird_y_t bird_y,
	input  flappy_pkg::pipe_x_t pipe_x,
	input  flappy_pkg::gap_y_t  gap0,
	input  flappy_pkg::gap_y_t  gap1,
	input  flappy_pkg::score_t  score,
	output logic                hsync,
	output logic                vsync,
	output flappy_pkg::red_t    red,
	output flappy_pkg::green_t  green,
	output flappy_pkg::blue_t   blue,
	output logic                collide,
	output flappy_pkg::seg_t    seg,
	output flappy_pkg::anode_t  an
);

	import flappy_pkg::*;

	// Raster position shared by renderer
	hcount_t hc;
	vcount_t vc;
	logic    line_end;

	vga_timing u_timing (
		.clk     (clk),
		.clr     (clr),
		.hc      (hc),
		.vc      (vc),
		.hsync   (hsync),
		.vsync   (vsync),
		.line_end(line_end)
	);

	pixel_render u_render (
		.clk    (clk),
		.clr    (clr),
		.hc     (hc),
		.vc     (vc),
		.bird_y (bird_y),
		.pipe_x (pipe_x),
		.gap0   (gap0),
		.gap1   (gap1),
		.score  (score),
		.red    (red),
		.green  (green),
		.blue   (blue),
		.collide(collide)
	);

	// Scanner paced by the line strobe
	seg_scan u_scan (
		.clk     (clk),
		.clr     (clr),
		.line_end(line_end),
		.score   (score),
		.seg     (seg),
		.an      (an)
	);

endmodule

//--- tb/tb_flappy_display.sv
`timescale 1ns/1ns
`include "vga_defs.svh"

module tb_flappy_display;

	import flappy_pkg::*;

	// Three frames of raster
	localparam int RUN_FRAMES = 3;
	// About 4% above 3 x 800 x 521 cycles
	localparam int TIMEOUT_CYCLES = 1_300_000;

	logic    clk;
	logic    clr;
	bird_y_t bird_y;
	pipe_x_t pipe_x;
	gap_y_t  gap0;
	gap_y_t  gap1;
	score_t  score;
	logic    hsync;
	logic    vsync;
	red_t    red;
	green_t  green;
	blue_t   blue;
	logic    collide;
	seg_t    seg;
	anode_t  an;

	// Reference raster and scanner
	int          mhc;
	int          mvc;
	int          mframe;
	int          cycles = 0;
	integer      seed;
	logic [7:0]  exp_rgb;
	logic        exp_hit;
	logic        exp_collide;
	logic        collide_seen;
	scan_state_t mstate;
	anode_t      exp_an;
	seg_t        exp_seg;

	flappy_display_top dut (
		.clk    (clk),
		.clr    (clr),
		.bird_y (bird_y),
		.pipe_x (pipe_x),
		.gap0   (gap0),
		.gap1   (gap1),
		.score  (score),
		.hsync  (hsync),
		.vsync  (vsync),
		.red    (red),
		.green  (green),
		.blue   (blue),
		.collide(collide),
		.seg    (seg),
		.an     (an)
	);

	//////////////////////////////////////////////////
	// Geometry model
	//////////////////////////////////////////////////

	function automatic bit in_bird(int h, int v, int by);
		int centre;
		centre = `FLOOR_Y - by;
		return (v > centre - `BIRD_HALF) && (v < centre + `BIRD_HALF) &&
			(h > `H_BP + `BIRD_X0) && (h < `H_BP + `BIRD_X1);
	endfunction

	// Solid column outside the gap and above the grass
	function automatic bit in_pipe(int h, int v, int left, int gap);
		return (h > left) && (h < left + `PIPE_W) &&
			((v < gap + `GAP_TOP) || ((v > gap + `GAP_BOT) && (v < `GRASS_Y)));
	endfunction

	function automatic bit in_bar(int h, int v, int sc);
		int lo;
		bit hit;
		hit = 0;
		if ((v >= `SCORE_Y0) && (v <= `SCORE_Y1))
		begin
			for (int k = 1; k <= 15; k++)
			begin
				lo = `H_BP + `BAR_X0 + `BAR_PITCH * (k - 1);
				if ((sc >= k) && (h > lo) && (h < lo + `BAR_W))
					hit = 1;
			end
		end
		return hit;
	endfunction

	// Glyphs written active high as gfedcba and then inverted
	function automatic logic [6:0] glyph_of(int d);
		logic [6:0] lit;
		case (d)
			0: lit = 7'h3F;
			1: lit = 7'h06;
			2: lit = 7'h5B;
			3: lit = 7'h4F;
			4: lit = 7'h66;
			5: lit = 7'h6D;
			6: lit = 7'h7D;
			7: lit = 7'h07;
			8: lit = 7'h7F;
			9: lit = 7'h6F;
			10: lit = 7'h77;
			11: lit = 7'h7C;
			12: lit = 7'h39;
			13: lit = 7'h5E;
			14: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	always_comb
	begin
		int p1_left;
		bit b;
		bit p0;
		bit p1;
		p1_left = `H_FP - int'(pipe_x);
		b = in_bird(mhc, mvc, int'(bird_y));
		p1 = in_pipe(mhc, mvc, p1_left, int'(gap1));
		p0 = in_pipe(mhc, mvc, p1_left - `PIPE_SPACING, int'(gap0));
		exp_hit = b && (p0 || p1);
		// Priority order is blanking, bars, bird, pipes, grass and sky
		if (!((mvc >= `V_BP) && (mvc < `V_FP) && (mhc >= `H_BP) && (mhc < `H_FP)))
			exp_rgb = `BLACK;
		else if (in_bar(mhc, mvc, int'(score)))
			exp_rgb = `WHITE;
		else if (b)
			exp_rgb = `BLACK;
		else if (p1 || p0)
			exp_rgb = `RED;
		else if (mvc >= `GRASS_Y)
			exp_rgb = `GREEN;
		else
			exp_rgb = `CYAN;
	end

	//////////////////////////////////////////////////
	// Reference counters and scanner
	//////////////////////////////////////////////////

	always @(posedge clk or posedge clr)
	begin
		if (clr)
		begin
			mhc <= 0;
			mvc <= 0;
			mframe <= 0;
			exp_collide <= 1'b0;
		end
		else
		begin
			exp_collide <= exp_hit;
			if (mhc == `H_TOTAL - 1)
			begin
				mhc <= 0;
				// Last line closes the frame
				if (mvc == `V_TOTAL - 1)
				begin
					mvc <= 0;
					mframe <= mframe + 1;
				end
				else
					mvc <= mvc + 1;
			end
			else
				mhc <= mhc + 1;
		end
	end

	// One digit step per line end
	always @(posedge clk or posedge clr)
	begin
		if (clr)
		begin
			mstate <= DIG_LEFT;
			exp_an <= 4'b1111;
			exp_seg <= 7'b1111111;
		end
		else if (mhc == `H_TOTAL - 1)
		begin
			case (mstate)
				DIG_LEFT:
				begin
					mstate <= DIG_MIDLEFT;
					exp_an <= 4'b1011;
					exp_seg <= glyph_of(0);
				end
				DIG_MIDLEFT:
				begin
					mstate <= DIG_MIDRIGHT;
					exp_an <= 4'b1101;
					exp_seg <= glyph_of(0);
				end
				DIG_MIDRIGHT:
				begin
					mstate <= DIG_RIGHT;
					exp_an <= 4'b1110;
					exp_seg <= glyph_of(int'(score));
				end
				default:
				begin
					mstate <= DIG_LEFT;
					exp_an <= 4'b0111;
					exp_seg <= glyph_of(0);
				end
			endcase
		end
	end

	always @(posedge clk or posedge clr)
	begin
		if (clr)
			collide_seen <= 1'b0;
		else if (collide)
			collide_seen <= 1'b1;
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic stop_run(string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	a_sync: assert property (@(posedge clk) disable iff (clr)
		(hsync == (mhc >= `H_PULSE)) && (vsync == (mvc >= `V_PULSE)))
		else stop_run($sformatf("FAIL at %0t ns: sync at hc=%0d vc=%0d, got hsync=%b vsync=%b",
			$time, $sampled(mhc), $sampled(mvc), $sampled(hsync), $sampled(vsync)));

	a_colour: assert property (@(posedge clk) disable iff (clr) {red, green, blue} == exp_rgb)
		else stop_run($sformatf("FAIL at %0t ns: colour at hc=%0d vc=%0d, exp %h got %h",
			$time, $sampled(mhc), $sampled(mvc), $sampled(exp_rgb),
			$sampled({red, green, blue})));

	a_collide: assert property (@(posedge clk) disable iff (clr) collide == exp_collide)
		else stop_run($sformatf("FAIL at %0t ns: collide exp %b got %b",
			$time, $sampled(exp_collide), $sampled(collide)));

	a_scan: assert property (@(posedge clk) disable iff (clr) (an == exp_an) && (seg == exp_seg))
		else stop_run($sformatf("FAIL at %0t ns: scanner exp an=%b seg=%b got an=%b seg=%b",
			$time, $sampled(exp_an), $sampled(exp_seg), $sampled(an), $sampled(seg)));

	// Frame 0 is set up so the bird overlaps pipe 1
	a_hit_seen: assert property (@(posedge clk) disable iff (clr)
		((mframe == 1) && (mhc == 0) && (mvc == 0)) |-> collide_seen)
		else stop_run($sformatf("FAIL at %0t ns: collide never went high during frame 0", $time));

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			stop_run($sformatf("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES));
	end

	//////////////////////////////////////////////////
	// Clock and stimulus
	//////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic draw_inputs();
		bird_y = bird_y_t'({$random(seed)} % 481);
		pipe_x = pipe_x_t'($random(seed));
		gap0 = gap_y_t'($random(seed));
		gap1 = gap_y_t'($random(seed));
		score = score_t'($random(seed));
	endtask

	initial
	begin
		seed = 2;
		clr = 1'b1;
		// Bird rows 261..299 inside pipe 1 lower column at hc 274..283
		bird_y = 10'd200;
		pipe_x = 9'd511;
		gap0 = 8'd100;
		gap1 = 8'd10;
		score = 4'hF;
		repeat (3) @(posedge clk);
		#1 clr = 1'b0;
		for (int f = 1; f <= RUN_FRAMES; f++)
		begin
			// New game state at each raster wrap
			while (mframe != f)
			begin
				@(posedge clk);
				#1;
			end
			if (f < RUN_FRAMES)
				draw_inputs();
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- flist.f
+incdir+rtl
rtl/flappy_pkg.sv
rtl/vga_timing.sv
rtl/pixel_render.sv
rtl/hex_to_seg.sv
rtl/seg_scan.sv
rtl/flappy_display_top.sv
tb/tb_flappy_display.sv

//--- Bender.yml
package:
  name: flappy_display

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/flappy_pkg.sv
      - rtl/vga_timing.sv
      - rtl/pixel_render.sv
      - rtl/hex_to_seg.sv
      - rtl/seg_scan.sv
      - rtl/flappy_display_top.sv
  - target: test
    files:
      - tb/tb_flappy_display.sv
